/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f tb.f --top-module strand_frontend_tb \
	&& ./obj_dir/Vstrand_frontend_tb \
	|| exit 1

/* source/fetch_router.sv */
`timescale 1ns/100ps

module fetch_router (
	input logic fetch_valid_i,
	input strand_pkg::fetch_bundle_t fetch_bundle_i,
	output logic fetch_ready_o,
	input strand_pkg::strand_mask_t queue_ready_i,
	input strand_pkg::strand_mask_t rollback_i,
	output strand_pkg::strand_mask_t push_o,
	output strand_pkg::queue_entry_t entry_o
);

	strand_pkg::strand_mask_t strand_sel;
	strand_pkg::strand_id_t target;

	assign target = fetch_bundle_i.strand_id;

	// One-hot decode of the target strand
	always_comb
	begin
		strand_sel = '0;
		for (int s = 0; s < strand_pkg::NUM_STRANDS; s++)
		begin
			if (int'(target) == s)
				strand_sel[s] = 1'b1;
		end
	end

	// A strand under rollback takes no new word this cycle
	always_comb
	begin
		if (fetch_valid_i)
			push_o = strand_sel & ~rollback_i;
		else
			push_o = '0;
	end

	// Ready follows the addressed queue only
	assign fetch_ready_o = queue_ready_i[target];

	// Strand id dropped, the queue index carries it
	always_comb
	begin
		entry_o.pc = fetch_bundle_i.pc;
		entry_o.instruction = fetch_bundle_i.instruction;
	end

endmodule

/* source/strand_frontend.sv */
`timescale 1ns/100ps

module strand_frontend (
	input logic clk,
	input logic rst_n_i,
	input logic fetch_valid_i,
	input strand_pkg::fetch_bundle_t fetch_bundle_i,
	output logic fetch_ready_o,
	input strand_pkg::strand_mask_t strand_enable_i,
	input strand_pkg::strand_mask_t suspend_i,
	input strand_pkg::strand_mask_t resume_i,
	input strand_pkg::strand_mask_t rollback_i,
	output logic issue_valid_o,
	output strand_pkg::issue_bundle_t issue_bundle_o,
	input logic issue_ready_i,
	output logic halt_o
);

	strand_pkg::strand_mask_t queue_ready;
	strand_pkg::strand_mask_t queue_push;
	strand_pkg::strand_mask_t queue_valid;
	strand_pkg::strand_mask_t queue_pop;
	strand_pkg::queue_entry_t router_entry;	// Shared by all queues, push selects
	strand_pkg::queue_entry_t [strand_pkg::NUM_STRANDS-1:0] queue_head;

	fetch_router u_fetch_router (
		.fetch_valid_i(fetch_valid_i),
		.fetch_bundle_i(fetch_bundle_i),
		.fetch_ready_o(fetch_ready_o),
		.queue_ready_i(queue_ready),
		.rollback_i(rollback_i),
		.push_o(queue_push),
		.entry_o(router_entry)
	);

	// One queue per strand
	for (genvar i = 0; i < strand_pkg::NUM_STRANDS; i++)
	begin : g_queue
		strand_queue u_strand_queue (
			.clk(clk),
			.rst_n_i(rst_n_i),
			.push_i(queue_push[i]),
			.entry_i(router_entry),
			.ready_o(queue_ready[i]),
			.flush_i(rollback_i[i]),
			.pop_i(queue_pop[i]),
			.valid_o(queue_valid[i]),
			.head_o(queue_head[i])
		);
	end

	strand_select u_strand_select (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.queue_valid_i(queue_valid),
		.queue_head_i(queue_head),
		.pop_o(queue_pop),
		.strand_enable_i(strand_enable_i),
		.suspend_i(suspend_i),
		.resume_i(resume_i),
		.rollback_i(rollback_i),
		.issue_valid_o(issue_valid_o),
		.issue_bundle_o(issue_bundle_o),
		.issue_ready_i(issue_ready_i),
		.halt_o(halt_o)
	);

endmodule

/* source/strand_pkg.sv */
package strand_pkg;

	// Strand configuration
	localparam int NUM_STRANDS = 4;
	localparam int STRAND_W = $clog2(NUM_STRANDS);

	// Per-strand instruction queue
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);	// Holds 0..QUEUE_DEPTH

	localparam int PC_W = 32;
	localparam int INSTR_W = 32;

	typedef logic [STRAND_W-1:0] strand_id_t;
	typedef logic [NUM_STRANDS-1:0] strand_mask_t;	// One bit per strand

	// From instruction fetch
	typedef struct packed
	{
		strand_id_t strand_id;
		logic [PC_W-1:0] pc;
		logic [INSTR_W-1:0] instruction;
	} fetch_bundle_t;

	// Queue storage, strand implied by queue index
	typedef struct packed
	{
		logic [PC_W-1:0] pc;
		logic [INSTR_W-1:0] instruction;
	} queue_entry_t;

	// To decode
	typedef struct packed
	{
		strand_id_t strand_id;
		logic [PC_W-1:0] pc;
		logic [INSTR_W-1:0] instruction;
	} issue_bundle_t;

endpackage

/* source/strand_queue.sv */
`timescale 1ns/100ps

module strand_queue (
	input logic clk,
	input logic rst_n_i,
	input logic push_i,
	input strand_pkg::queue_entry_t entry_i,
	output logic ready_o,
	input logic flush_i,
	input logic pop_i,
	output logic valid_o,
	output strand_pkg::queue_entry_t head_o
);

	strand_pkg::queue_entry_t mem [strand_pkg::QUEUE_DEPTH];
	logic [strand_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
	logic [strand_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
	logic [strand_pkg::QUEUE_CNT_W-1:0] count_q;
	logic do_push;
	logic do_pop;

	// Wraps at QUEUE_DEPTH, also for a depth that is not a power of two
	function automatic logic [strand_pkg::QUEUE_PTR_W-1:0] ptr_inc(
		input logic [strand_pkg::QUEUE_PTR_W-1:0] ptr);
		if (int'(ptr) == strand_pkg::QUEUE_DEPTH - 1)
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	assign valid_o = count_q != '0;
	assign ready_o = int'(count_q) != strand_pkg::QUEUE_DEPTH;	// Not full

	assign do_push = push_i && ready_o && !flush_i;
	assign do_pop = pop_i && valid_o && !flush_i;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end
		else if (flush_i)
		begin
			// Rollback drops every queued word
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= ptr_inc(rd_ptr_q);

			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;	// Idle or push with pop
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr_q] <= entry_i;
	end

	assign head_o = mem[rd_ptr_q];

endmodule

/* source/strand_select.sv */
`timescale 1ns/100ps

module strand_select (
	input logic clk,
	input logic rst_n_i,
	input strand_pkg::strand_mask_t queue_valid_i,
	input strand_pkg::queue_entry_t [strand_pkg::NUM_STRANDS-1:0] queue_head_i,
	output strand_pkg::strand_mask_t pop_o,
	input strand_pkg::strand_mask_t strand_enable_i,
	input strand_pkg::strand_mask_t suspend_i,
	input strand_pkg::strand_mask_t resume_i,
	input strand_pkg::strand_mask_t rollback_i,
	output logic issue_valid_o,
	output strand_pkg::issue_bundle_t issue_bundle_o,
	input logic issue_ready_i,
	output logic halt_o
);

	strand_pkg::strand_mask_t suspended_q;
	strand_pkg::strand_mask_t eligible;
	strand_pkg::strand_id_t rr_ptr_q;
	strand_pkg::strand_id_t cand;
	strand_pkg::strand_id_t winner;
	logic found;
	logic load_en;
	logic held_cancel;
	logic issue_valid_q;
	strand_pkg::issue_bundle_t issue_bundle_q;

	assign eligible = queue_valid_i & strand_enable_i & ~suspended_q & ~rollback_i;

	// Output register free, or its bundle leaves this cycle
	assign load_en = !issue_valid_q || issue_ready_i;

	assign held_cancel = issue_valid_q && rollback_i[issue_bundle_q.strand_id];

	// First eligible strand at or after the pointer
	always_comb
	begin
		found = 1'b0;
		winner = rr_ptr_q;
		cand = rr_ptr_q;
		for (int k = 0; k < strand_pkg::NUM_STRANDS; k++)
		begin
			cand = rr_ptr_q + k[strand_pkg::STRAND_W-1:0];
			if (!found && eligible[cand])
			begin
				found = 1'b1;
				winner = cand;
			end
		end
	end

	always_comb
	begin
		pop_o = '0;
		if (load_en && found)
			pop_o[winner] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			suspended_q <= '0;
			rr_ptr_q <= '0;
			issue_valid_q <= 1'b0;
		end
		else
		begin
			// Suspend wins over a resume in the same cycle
			suspended_q <= (suspended_q & ~resume_i) | suspend_i;

			if (load_en)
			begin
				issue_valid_q <= found;
				if (found)
					rr_ptr_q <= winner + 1'b1;	// Strand after the winner
			end
			else if (held_cancel)
			begin
				issue_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load_en && found)
		begin
			issue_bundle_q.strand_id <= winner;
			issue_bundle_q.pc <= queue_head_i[winner].pc;
			issue_bundle_q.instruction <= queue_head_i[winner].instruction;
		end
	end

	assign issue_valid_o = issue_valid_q;
	assign issue_bundle_o = issue_bundle_q;

	assign halt_o = strand_enable_i == '0;	// No strand left to run

endmodule

/* tb.f */
source/strand_pkg.sv
source/fetch_router.sv
source/strand_queue.sv
source/strand_select.sv
source/strand_frontend.sv
verif/strand_frontend_props.sv
verif/strand_frontend_tb.sv

/* verif/strand_frontend_props.sv */
`timescale 1ns/100ps

module strand_frontend_props (
	input logic clk,
	input logic rst_n_i,
	input strand_pkg::strand_mask_t pop_i,
	input strand_pkg::strand_mask_t strand_enable_i,
	input strand_pkg::strand_mask_t suspend_i,
	input strand_pkg::strand_mask_t resume_i,
	input strand_pkg::strand_mask_t rollback_i,
	input logic issue_valid_i,
	input strand_pkg::issue_bundle_t issue_bundle_i,
	input logic issue_ready_i,
	input logic halt_i
);

	strand_pkg::strand_mask_t suspended_q;	// Rebuilt from the pulses

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			suspended_q <= '0;
		else
			suspended_q <= (suspended_q & ~resume_i) | suspend_i;	// Suspend wins
	end

	// Held bundle stays unless its own strand rolls back
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		issue_valid_i && !issue_ready_i && !rollback_i[issue_bundle_i.strand_id]
		|=> issue_valid_i && $stable(issue_bundle_i))
		else $error("issue bundle changed while decode stalled");

	no_pop_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		issue_valid_i && !issue_ready_i |-> pop_i == '0)
		else $error("queue popped while the output was held");

	pick_allowed: assert property (@(posedge clk) disable iff (!rst_n_i)
		(pop_i & (suspended_q | ~strand_enable_i)) == '0)
		else $error("suspended or disabled strand was picked");

	idle_in_reset: assert property (@(posedge clk) !rst_n_i |-> !issue_valid_i)
		else $error("issue valid high during reset");

	halt_when_disabled: assert property (@(posedge clk) halt_i == (strand_enable_i == '0))
		else $error("halt does not follow the enable mask");

endmodule

/* verif/strand_frontend_tb.sv */
`timescale 1ns/100ps

module strand_frontend_tb;

	localparam int TIMEOUT = 2000;	// Cycles
	localparam int NS = strand_pkg::NUM_STRANDS;

	logic clk;
	logic rst_n_i;
	logic fetch_valid_i;
	strand_pkg::fetch_bundle_t fetch_bundle_i;
	logic fetch_ready_o;
	strand_pkg::strand_mask_t strand_enable_i;
	strand_pkg::strand_mask_t suspend_i;
	strand_pkg::strand_mask_t resume_i;
	strand_pkg::strand_mask_t rollback_i;
	logic issue_valid_o;
	strand_pkg::issue_bundle_t issue_bundle_o;
	logic issue_ready_i;
	logic halt_o;

	logic [31:0] lfsr_state;
	int ready_mode;	// 0 random stalls, 1 held high, 2 held low
	int stall_left;
	string test_name;
	logic rr_check;
	logic rr_have_prev;
	strand_pkg::strand_id_t rr_prev;
	logic fetch_took;	// Fetch transfer at the coming edge
	int issued_count [NS];
	logic [31:0] pc_next [NS];
	strand_pkg::issue_bundle_t exp_q [NS][$];	// Fetched and not yet issued

	strand_frontend u_strand_frontend (.*);

	bind strand_select strand_frontend_props u_strand_frontend_props (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.pop_i(pop_o),
		.strand_enable_i(strand_enable_i),
		.suspend_i(suspend_i),
		.resume_i(resume_i),
		.rollback_i(rollback_i),
		.issue_valid_i(issue_valid_o),
		.issue_bundle_i(issue_bundle_o),
		.issue_ready_i(issue_ready_i),
		.halt_i(halt_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32 22 2 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	// After the next edge the pulses drop and issue_ready_i follows the mode
	task automatic tick();
		@(posedge clk);
		#1;
		suspend_i = '0;
		resume_i = '0;
		rollback_i = '0;
		if (ready_mode == 1)
			issue_ready_i = 1'b1;
		else if (ready_mode == 2 || stall_left > 0)
		begin
			issue_ready_i = 1'b0;
			stall_left = (stall_left > 0) ? stall_left - 1 : 0;
		end
		else if (rand_bits(3) == 0)
		begin
			issue_ready_i = 1'b0;
			stall_left = int'(rand_bits(4));
		end
		else
			issue_ready_i = 1'b1;
	endtask

	task automatic send_fetch(input int s);
		int waited;
		waited = 0;
		fetch_bundle_i.strand_id = strand_pkg::strand_id_t'(s);
		fetch_bundle_i.pc = pc_next[s];
		fetch_bundle_i.instruction = rand_bits(32);
		fetch_valid_i = 1'b1;
		tick();
		while (!fetch_took)
		begin
			if (waited == TIMEOUT)
				abort_run($sformatf("fetch to strand %0d was never accepted", s));
			tick();
			waited++;
		end
		pc_next[s] = pc_next[s] + 32'd4;
		fetch_valid_i = 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		int pending;
		waited = 0;
		pending = 1;
		while (pending != 0)
		begin
			if (waited == TIMEOUT)
				abort_run($sformatf("%s: queued instructions never issued", test_name));
			tick();
			waited++;
			pending = int'(issue_valid_o);
			for (int s = 0; s < NS; s++)
				pending += exp_q[s].size();
		end
	endtask

	task automatic check_issue();
		strand_pkg::issue_bundle_t expected;
		strand_pkg::strand_id_t s;
		strand_pkg::strand_id_t next_rr;
		s = issue_bundle_o.strand_id;
		next_rr = rr_prev + 1'b1;
		assert (exp_q[s].size() > 0)
		else
			abort_run($sformatf("%s: strand %0d issued with nothing fetched", test_name, s));
		expected = exp_q[s].pop_front();
		assert (issue_bundle_o == expected)
		else
			abort_run($sformatf("MISMATCH %s: expected %h actual %h", test_name,
				expected, issue_bundle_o));
		assert (!rr_check || !rr_have_prev || s == next_rr)
		else
			abort_run($sformatf("MISMATCH %s: expected strand %0d actual %0d", test_name,
				next_rr, s));
		issued_count[s]++;
		rr_prev = s;
		rr_have_prev = rr_check;
	endtask

	// Scoreboard runs at the falling edge where every signal is settled
	always @(negedge clk)
	begin : monitor
		strand_pkg::issue_bundle_t entry;
		int queued;
		logic exp_ready;
		entry = strand_pkg::issue_bundle_t'(fetch_bundle_i);
		fetch_took = rst_n_i && fetch_valid_i && fetch_ready_o;
		if (rst_n_i)
		begin
			// The held output bundle has already left its queue
			queued = exp_q[entry.strand_id].size();
			if (issue_valid_o && issue_bundle_o.strand_id == entry.strand_id)
				queued--;
			exp_ready = queued < strand_pkg::QUEUE_DEPTH;
			assert (fetch_ready_o == exp_ready)
			else
				abort_run($sformatf("MISMATCH %s: expected fetch ready %b actual %b",
					test_name, exp_ready, fetch_ready_o));
		end
		if (!rr_check)
			rr_have_prev = 1'b0;
		if (rst_n_i && issue_valid_o && issue_ready_i)
			check_issue();
		for (int s = 0; s < NS; s++)
			if (rollback_i[s])
				exp_q[s].delete();
		if (fetch_took && !rollback_i[entry.strand_id])	// Router drops it otherwise
			exp_q[entry.strand_id].push_back(entry);
	end

	initial
	begin : main
		int waited;
		int base0;
		int base2;
		lfsr_state = 32'h0d9f35f7;
		rst_n_i = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_bundle_i = '0;
		strand_enable_i = '1;
		suspend_i = '0;
		resume_i = '0;
		rollback_i = '0;
		issue_ready_i = 1'b0;
		ready_mode = 0;
		stall_left = 0;
		rr_check = 1'b0;
		test_name = "random_rollback";
		for (int s = 0; s < NS; s++)
			pc_next[s] = 32'(s) << 28;
		repeat (10) @(posedge clk);
		#1;
		rst_n_i = 1'b1;

		for (int n = 0; n < 200; n++)
		begin
			if (rand_bits(5) == 0)
				rollback_i[strand_pkg::strand_id_t'(rand_bits(2))] = 1'b1;
			send_fetch(int'(rand_bits(2)));
		end
		wait_drained();

		// Held bundle of a rolled back strand is dropped
		test_name = "rollback_held";
		ready_mode = 2;
		send_fetch(1);
		send_fetch(1);
		rollback_i[1] = 1'b1;
		tick();
		assert (!issue_valid_o)
		else
			abort_run($sformatf("MISMATCH %s: expected 0 actual %b", test_name, issue_valid_o));
		ready_mode = 0;
		wait_drained();

		test_name = "round_robin";
		rr_check = 1'b1;
		ready_mode = 2;
		for (int s = 0; s < NS; s++)
			repeat (strand_pkg::QUEUE_DEPTH) send_fetch(s);
		ready_mode = 1;
		wait_drained();
		rr_check = 1'b0;

		test_name = "suspend_resume";
		ready_mode = 0;
		base0 = issued_count[0];
		base2 = issued_count[2];
		suspend_i[2] = 1'b1;
		strand_enable_i = 4'b1110;
		send_fetch(2);
		send_fetch(2);
		send_fetch(0);
		repeat (60) send_fetch((rand_bits(1) == 0) ? 1 : 3);
		assert (issued_count[0] == base0 && issued_count[2] == base2)
		else
			abort_run($sformatf("MISMATCH %s: expected %0d %0d actual %0d %0d", test_name,
				base0, base2, issued_count[0], issued_count[2]));
		resume_i[2] = 1'b1;
		strand_enable_i = '1;
		waited = 0;
		while (issued_count[0] == base0 || issued_count[2] == base2)
		begin
			if (waited == TIMEOUT)
				abort_run("strand 0 or strand 2 did not issue after resume");
			tick();
			waited++;
		end
		wait_drained();

		test_name = "halt";
		strand_enable_i = '0;
		send_fetch(3);
		assert (halt_o)
		else
			abort_run($sformatf("MISMATCH %s: expected 1 actual %b", test_name, halt_o));
		repeat (4) tick();
		strand_enable_i = '1;
		tick();
		assert (!halt_o)
		else
			abort_run($sformatf("MISMATCH %s: expected 0 actual %b", test_name, halt_o));
		ready_mode = 1;
		wait_drained();

		$display("all tests passed");
		$finish;
	end

endmodule
